// File: logic/starMix_params.svh
// size macros for the star layer mixer, included by the package and the testbench
`ifndef STAR_MIX_PARAMS_SVH
`define STAR_MIX_PARAMS_SVH

// ==========================================================================
// strip geometry
// ==========================================================================

// layers per strip, tiles arrive in layer order 0, 1, 2
`define STAR_NUM_LAYERS 3

// bitplanes per tile, plane 0 is the pixel LSB
`define STAR_PLANES 3

// pixels per tile row, same as the width of one plane byte
`define STAR_TILE_W 8

// palette bank width
`define STAR_PAL_W 4

`endif

// File: logic/starMixPkg.sv
// shared pixel, plane and colour types, imported by every block of the layer mixer
`include "starMix_params.svh"

package starMixPkg;

   // ==========================================================================
   // tile data
   // ==========================================================================

   // one bitplane row of a tile, MSB is the leftmost pixel
   typedef logic [`STAR_TILE_W-1:0] planeByte_t;

   // all planes of one tile, plane 0 in the low byte
   typedef planeByte_t [`STAR_PLANES-1:0] tilePlanes_t;

   // palette bank attached to a tile
   typedef logic [`STAR_PAL_W-1:0] palette_t;

   // ==========================================================================
   // pixel data
   // ==========================================================================

   // one pixel, value 0 is transparent
   typedef logic [`STAR_PLANES-1:0] pixel_t;

   // bank on top, pixel value below
   typedef logic [`STAR_PAL_W+`STAR_PLANES-1:0] colorIndex_t;

   // layer number, 3 marks background
   typedef logic [1:0] layerIdx_t;

endpackage

// File: logic/tileLoader.sv
// tile intake: stages one strip of tiles, hands full strips to the lanes, paces the shifts
`timescale 1ns/1ps
`include "starMix_params.svh"

module tileLoader
(
   input  logic                   clk,
   input  logic                   CR,
   input  logic                   tileValid_i,
   output logic                   tileReady_o,
   input  starMixPkg::tilePlanes_t tilePlanes_i,
   input  starMixPkg::palette_t   tilePalette_i,
   output logic                   loadLanes_o,
   output logic                   shiftLanes_o,
   output logic                   laneValid_o,
   input  logic                   laneReady_i,
   output starMixPkg::tilePlanes_t lanePlanes_o [`STAR_NUM_LAYERS],
   output starMixPkg::palette_t   lanePalette_o [`STAR_NUM_LAYERS]
);

   import starMixPkg::*;

   localparam int CNT_W = $clog2(`STAR_TILE_W);

   // staging strip, one slot per layer
   tilePlanes_t stagePlanes [`STAR_NUM_LAYERS];
   palette_t    stagePal [`STAR_NUM_LAYERS];
   logic        stageFull;
   layerIdx_t   layerCnt;
   logic [`STAR_NUM_LAYERS-1:0] slotSel;

   // strip held in the lanes
   logic             laneValid;
   logic [CNT_W-1:0] pixCnt;
   logic             lastPix;
   logic             lanesFree;
   logic             tileAccept;

   // ==========================================================================
   // staging side
   // ==========================================================================

   assign tileReady_o = !stageFull;
   assign tileAccept  = tileValid_i && !stageFull;

   // slot decode from the layer counter, one enable per layer
   always_comb
   begin
      for (int l = 0; l < `STAR_NUM_LAYERS; l++)
      begin
         slotSel[l] = tileAccept && (layerCnt == layerIdx_t'(l));
      end
   end

   always_ff @(posedge clk)
   begin
      for (int l = 0; l < `STAR_NUM_LAYERS; l++)
      begin
         if (slotSel[l])
         begin
            stagePlanes[l] <= tilePlanes_i;
            stagePal[l]    <= tilePalette_i;
         end
      end
   end

   // layer counter wraps once the last slot fills
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         layerCnt  <= '0;
         stageFull <= 1'b0;
      end
      else if (loadLanes_o)
      begin
         stageFull <= 1'b0;
      end
      else if (tileAccept)
      begin
         if (layerCnt == layerIdx_t'(`STAR_NUM_LAYERS-1))
         begin
            layerCnt  <= '0;
            stageFull <= 1'b1;
         end
         else
         begin
            layerCnt <= layerCnt + 1'b1;
         end
      end
   end

   // ==========================================================================
   // lane side
   // ==========================================================================

   assign lastPix      = (pixCnt == CNT_W'(`STAR_TILE_W-1));
   assign shiftLanes_o = laneValid && laneReady_i;

   // lanes count as free when the eighth pixel leaves this cycle
   assign lanesFree   = !laneValid || (shiftLanes_o && lastPix);
   assign loadLanes_o = stageFull && lanesFree;

   assign laneValid_o   = laneValid;
   assign lanePlanes_o  = stagePlanes;
   assign lanePalette_o = stagePal;

   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         laneValid <= 1'b0;
         pixCnt    <= '0;
      end
      else if (loadLanes_o)
      begin
         laneValid <= 1'b1;
         pixCnt    <= '0;
      end
      else if (shiftLanes_o)
      begin
         pixCnt <= pixCnt + 1'b1;
         if (lastPix)
            laneValid <= 1'b0;
      end
   end

endmodule

// File: logic/planeLane.sv
// one layer lane: 74194 style shift registers per bitplane plus the held palette bank
`timescale 1ns/1ps
`include "starMix_params.svh"

module planeLane
(
   input  logic                    clk,
   input  logic                    CR,
   input  logic                    loadLanes_i,
   input  logic                    shiftLanes_i,
   input  starMixPkg::tilePlanes_t planes_i,
   input  starMixPkg::palette_t    palette_i,
   output starMixPkg::pixel_t      pixel_o,
   output starMixPkg::palette_t    palette_o
);

   import starMixPkg::*;

   tilePlanes_t planeQ;
   palette_t    palQ;
   logic [1:0]  modeSel;

   // 74194 mode pins, 11 load, 01 shift toward MSB, 00 hold
   assign modeSel = {loadLanes_i, loadLanes_i | shiftLanes_i};

   // ==========================================================================
   // per plane shift registers
   // ==========================================================================

   for (genvar p = 0; p < `STAR_PLANES; p++)
   begin : gPlane
      always_ff @(posedge clk or negedge CR)
      begin
         if (!CR)
         begin
            planeQ[p] <= '0;
         end
         else
         begin
            case (modeSel)
               2'b11:   planeQ[p] <= planes_i[p];
               // zero fill from the serial input
               2'b01:   planeQ[p] <= {planeQ[p][`STAR_TILE_W-2:0], 1'b0};
               default: planeQ[p] <= planeQ[p];
            endcase
         end
      end

      // leftmost pixel sits in the MSB
      assign pixel_o[p] = planeQ[p][`STAR_TILE_W-1];
   end

   // palette bank follows the tile for the whole strip
   always_ff @(posedge clk)
   begin
      if (loadLanes_i)
         palQ <= palette_i;
   end

   assign palette_o = palQ;

endmodule

// File: logic/priorityMixer.sv
// layer priority pick per pixel and the registered pixel output stage
`timescale 1ns/1ps
`include "starMix_params.svh"

module priorityMixer
(
   input  logic                    clk,
   input  logic                    CR,
   input  logic                    laneValid_i,
   output logic                    laneReady_o,
   input  starMixPkg::pixel_t      lanePixel_i [`STAR_NUM_LAYERS],
   input  starMixPkg::palette_t    lanePalette_i [`STAR_NUM_LAYERS],
   output logic                    pixValid_o,
   input  logic                    pixReady_i,
   output starMixPkg::colorIndex_t pixColor_o,
   output starMixPkg::layerIdx_t   pixLayer_o
);

   import starMixPkg::*;

   logic [`STAR_NUM_LAYERS-1:0] layerHit;
   layerIdx_t   winLayer;
   colorIndex_t winColor;
   logic        pixTake;

   logic        outValid;
   colorIndex_t outColor;
   layerIdx_t   outLayer;

   // ==========================================================================
   // priority encode and select
   // ==========================================================================

   // a layer shows when any plane bit is set
   always_comb
   begin
      for (int l = 0; l < `STAR_NUM_LAYERS; l++)
      begin
         layerHit[l] = |lanePixel_i[l];
      end
   end

   // walk from the back so the lowest hit layer wins
   always_comb
   begin
      winLayer = '1;
      winColor = '0;
      for (int l = `STAR_NUM_LAYERS-1; l >= 0; l--)
      begin
         if (layerHit[l])
         begin
            winLayer = layerIdx_t'(l);
            winColor = {lanePalette_i[l], lanePixel_i[l]};
         end
      end
   end

   // ==========================================================================
   // output register
   // ==========================================================================

   // room when empty or being drained this cycle
   assign laneReady_o = !outValid || pixReady_i;
   assign pixTake     = laneValid_i && laneReady_o;

   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
         outValid <= 1'b0;
      else if (pixTake)
         outValid <= 1'b1;
      else if (pixReady_i)
         outValid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (pixTake)
      begin
         outColor <= winColor;
         outLayer <= winLayer;
      end
   end

   assign pixValid_o = outValid;
   assign pixColor_o = outColor;
   assign pixLayer_o = outLayer;

endmodule

// File: logic/starLayerMixer.sv
// top level of the layer mixer: tile loader, one lane per layer, priority mixer
`timescale 1ns/1ps
`include "starMix_params.svh"

module starLayerMixer
(
   input  logic                    clk,
   input  logic                    CR,

   // tile input
   input  logic                    tileValid_i,
   output logic                    tileReady_o,
   input  starMixPkg::tilePlanes_t tilePlanes_i,
   input  starMixPkg::palette_t    tilePalette_i,

   // pixel output
   output logic                    pixValid_o,
   input  logic                    pixReady_i,
   output starMixPkg::colorIndex_t pixColor_o,
   output starMixPkg::layerIdx_t   pixLayer_o
);

   import starMixPkg::*;

   logic        loadLanes;
   logic        shiftLanes;
   logic        laneValid;
   logic        laneReady;
   tilePlanes_t lanePlanes [`STAR_NUM_LAYERS];
   palette_t    laneBank [`STAR_NUM_LAYERS];
   pixel_t      lanePixel [`STAR_NUM_LAYERS];
   palette_t    lanePalette [`STAR_NUM_LAYERS];

   // ==========================================================================
   // strip intake
   // ==========================================================================

   tileLoader tileLoader_i
   (
      .clk           (clk),
      .CR            (CR),
      .tileValid_i   (tileValid_i),
      .tileReady_o   (tileReady_o),
      .tilePlanes_i  (tilePlanes_i),
      .tilePalette_i (tilePalette_i),
      .loadLanes_o   (loadLanes),
      .shiftLanes_o  (shiftLanes),
      .laneValid_o   (laneValid),
      .laneReady_i   (laneReady),
      .lanePlanes_o  (lanePlanes),
      .lanePalette_o (laneBank)
   );

   // one lane per layer, all strobed together
   for (genvar l = 0; l < `STAR_NUM_LAYERS; l++)
   begin : gLane
      planeLane planeLane_i
      (
         .clk          (clk),
         .CR           (CR),
         .loadLanes_i  (loadLanes),
         .shiftLanes_i (shiftLanes),
         .planes_i     (lanePlanes[l]),
         .palette_i    (laneBank[l]),
         .pixel_o      (lanePixel[l]),
         .palette_o    (lanePalette[l])
      );
   end

   // ==========================================================================
   // layer select and output
   // ==========================================================================

   priorityMixer priorityMixer_i
   (
      .clk           (clk),
      .CR            (CR),
      .laneValid_i   (laneValid),
      .laneReady_o   (laneReady),
      .lanePixel_i   (lanePixel),
      .lanePalette_i (lanePalette),
      .pixValid_o    (pixValid_o),
      .pixReady_i    (pixReady_i),
      .pixColor_o    (pixColor_o),
      .pixLayer_o    (pixLayer_o)
   );

endmodule

// File: tb/starLayerMixer_assert.sv
// handshake assertions bound into the layer mixer top level from the testbench
`timescale 1ns/1ps

module starLayerMixer_assert
(
   input logic                    clk,
   input logic                    CR,
   input logic                    pixValid_o,
   input logic                    pixReady_i,
   input starMixPkg::colorIndex_t pixColor_o,
   input starMixPkg::layerIdx_t   pixLayer_o
);

   int failCount = 0;

   // output register comes out of reset empty
   resetEmpty: assert property (@(posedge clk) !CR |=> !pixValid_o)
   else
   begin
      failCount++;
      $error("pixel output valid right after reset");
   end

   // a stalled pixel keeps its value until taken
   holdWhileStalled: assert property (@(posedge clk) disable iff (!CR)
      pixValid_o && !pixReady_i |=> pixValid_o && $stable(pixColor_o) && $stable(pixLayer_o))
   else
   begin
      failCount++;
      $error("pixel output changed while stalled");
   end

   // two known bits always name layer 0 to 3
   layerInRange: assert property (@(posedge clk) disable iff (!CR)
      pixValid_o |-> !$isunknown(pixLayer_o))
   else
   begin
      failCount++;
      $error("pixel layer unknown or out of range");
   end

   // background always uses colour 0
   backgroundBlack: assert property (@(posedge clk) disable iff (!CR)
      pixValid_o && pixLayer_o == 2'd3 |-> pixColor_o == '0)
   else
   begin
      failCount++;
      $error("background pixel with non-zero colour");
   end

endmodule

// File: tb/starLayerMixer_tb.sv
// testbench for the layer mixer: seeded random strips against a queue model, run with sources.f
`timescale 1ns/1ps
`include "starMix_params.svh"

module starLayerMixer_tb;

   import starMixPkg::*;

   localparam int CLK_PERIOD     = 40;
   localparam int PRIO_STRIPS    = 20;
   localparam int BG_STRIPS      = 2;
   localparam int BP_STRIPS      = 30;
   localparam int STREAM_STRIPS  = 40;
   localparam int TOTAL_STRIPS   = PRIO_STRIPS + BG_STRIPS + BP_STRIPS + STREAM_STRIPS;
   localparam int TIMEOUT_CYCLES = TOTAL_STRIPS * `STAR_TILE_W * 4 + 200;
   localparam int MODE_SPARSE    = 0;
   localparam int MODE_ZERO      = 1;

   logic        clk;
   logic        CR;
   logic        tileValid_i;
   logic        tileReady_o;
   tilePlanes_t tilePlanes_i;
   palette_t    tilePalette_i;
   logic        pixValid_o;
   logic        pixReady_i;
   colorIndex_t pixColor_o;
   layerIdx_t   pixLayer_o;

   int          seed;
   int          errCount;
   int          checkCount;

   // reference model state
   tilePlanes_t stripPlanes [`STAR_NUM_LAYERS];
   palette_t    stripPal [`STAR_NUM_LAYERS];
   int          tileCnt;
   string       curTest;
   colorIndex_t expColorQ [$];
   layerIdx_t   expLayerQ [$];
   string       expTestQ [$];

   starLayerMixer starLayerMixer_i
   (
      .clk           (clk),
      .CR            (CR),
      .tileValid_i   (tileValid_i),
      .tileReady_o   (tileReady_o),
      .tilePlanes_i  (tilePlanes_i),
      .tilePalette_i (tilePalette_i),
      .pixValid_o    (pixValid_o),
      .pixReady_i    (pixReady_i),
      .pixColor_o    (pixColor_o),
      .pixLayer_o    (pixLayer_o)
   );

   bind starLayerMixer starLayerMixer_assert starLayerMixer_assert_i
   (
      .clk        (clk),
      .CR         (CR),
      .pixValid_o (pixValid_o),
      .pixReady_i (pixReady_i),
      .pixColor_o (pixColor_o),
      .pixLayer_o (pixLayer_o)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial
   begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, pixel stream stalled", TIMEOUT_CYCLES);
      $display("CHECKS FAILED");
      $finish;
   end

   // ==========================================================================
   // reference model
   // ==========================================================================

   // eight pixels per strip, lowest non-transparent layer wins
   task automatic expandStrip();
      tilePlanes_t tp;
      logic [2:0]  bitSel;
      pixel_t      pv;
      colorIndex_t color;
      layerIdx_t   layer;
      bit          found;
      for (int px = 0; px < `STAR_TILE_W; px++)
      begin
         bitSel = 3'(`STAR_TILE_W - 1 - px);
         color  = '0;
         layer  = 2'd3;
         found  = 1'b0;
         for (int l = 0; l < `STAR_NUM_LAYERS; l++)
         begin
            tp = stripPlanes[l];
            pv = {tp[2][bitSel], tp[1][bitSel], tp[0][bitSel]};
            if (!found && pv != 3'd0)
            begin
               found = 1'b1;
               layer = layerIdx_t'(l);
               color = {stripPal[l], pv};
            end
         end
         expColorQ.push_back(color);
         expLayerQ.push_back(layer);
         expTestQ.push_back(curTest);
      end
   endtask

   task automatic recordTile(input tilePlanes_t planes, input palette_t pal);
      stripPlanes[tileCnt] = planes;
      stripPal[tileCnt]    = pal;
      if (tileCnt == `STAR_NUM_LAYERS - 1)
      begin
         expandStrip();
         tileCnt = 0;
      end
      else
         tileCnt++;
   endtask

   task automatic checkPixel();
      string name;
      checkCount++;
      assert (expColorQ.size() > 0)
      else
      begin
         errCount++;
         $display("pixel came out while the model expected none");
      end
      if (expColorQ.size() > 0)
      begin
         name = expTestQ.pop_front();
         assert (pixColor_o == expColorQ[0])
         else
         begin
            errCount++;
            $display("Fail %s: color expected %0h actual %0h", name, expColorQ[0], pixColor_o);
         end
         assert (pixLayer_o == expLayerQ[0])
         else
         begin
            errCount++;
            $display("Fail %s: layer expected %0d actual %0d", name, expLayerQ[0], pixLayer_o);
         end
         void'(expColorQ.pop_front());
         void'(expLayerQ.pop_front());
      end
   endtask

   // handshakes settle well before the falling edge
   always @(negedge clk)
   begin
      if (CR)
      begin
         if (tileValid_i && tileReady_o)
            recordTile(tilePlanes_i, tilePalette_i);
         if (pixValid_o && pixReady_i)
            checkPixel();
      end
   end

   // ==========================================================================
   // stimulus
   // ==========================================================================

   function automatic planeByte_t randPlane(input int mode);
      logic [31:0] rnd;
      rnd = $random(seed);
      // sparse bytes are empty half the time
      if (mode == MODE_ZERO || rnd[8])
         return '0;
      return rnd[7:0];
   endfunction

   task automatic driveReady(input bit randReady);
      logic [31:0] rnd;
      rnd = $random(seed);
      pixReady_i = !randReady || (rnd[1:0] != 2'b00);
   endtask

   task automatic checkResetState(input string name);
      checkCount++;
      assert (!pixValid_o)
      else
      begin
         errCount++;
         $display("Fail %s: pixValid_o expected 0 actual %0b", name, pixValid_o);
      end
      assert (tileReady_o)
      else
      begin
         errCount++;
         $display("Fail %s: tileReady_o expected 1 actual %0b", name, tileReady_o);
      end
   endtask

   task automatic runStrips(input string name, input int strips, input int mode,
                            input bit randValid, input bit randReady);
      int          tilesLeft;
      bit          presenting;
      logic [31:0] rnd;
      tilesLeft  = strips * `STAR_NUM_LAYERS;
      presenting = 1'b0;
      curTest    = name;
      while (tilesLeft > 0)
      begin
         @(posedge clk);
         #2;
         driveReady(randReady);
         rnd = $random(seed);
         if (!presenting && (!randValid || rnd[0]))
         begin
            tilePlanes_i  = {randPlane(mode), randPlane(mode), randPlane(mode)};
            tilePalette_i = rnd[7:4];
            tileValid_i   = 1'b1;
            presenting    = 1'b1;
         end
         else if (!presenting)
            tileValid_i = 1'b0;
         // ready seen here means the tile goes in on the next edge
         @(negedge clk);
         if (presenting && tileReady_o)
         begin
            presenting = 1'b0;
            tilesLeft--;
         end
      end
      @(posedge clk);
      #2;
      tileValid_i = 1'b0;
   endtask

   task automatic drainOutputs(input bit randReady);
      while (expColorQ.size() > 0)
      begin
         @(posedge clk);
         #2;
         driveReady(randReady);
      end
   endtask

   initial
   begin
      seed          = 32'he552_f3a7;
      errCount      = 0;
      checkCount    = 0;
      tileCnt       = 0;
      curTest       = "reset";
      CR            = 1'b0;
      tileValid_i   = 1'b0;
      tilePlanes_i  = '0;
      tilePalette_i = '0;
      pixReady_i    = 1'b0;
      repeat (3)
      begin
         @(posedge clk);
         #2;
         checkResetState("reset");
      end
      CR = 1'b1;
      @(negedge clk);
      checkResetState("after reset");

      runStrips("priority", PRIO_STRIPS, MODE_SPARSE, 1'b0, 1'b0);
      drainOutputs(1'b0);
      runStrips("background", BG_STRIPS, MODE_ZERO, 1'b0, 1'b0);
      drainOutputs(1'b0);
      runStrips("backpressure", BP_STRIPS, MODE_SPARSE, 1'b1, 1'b1);
      drainOutputs(1'b1);
      runStrips("streaming", STREAM_STRIPS, MODE_SPARSE, 1'b0, 1'b0);
      drainOutputs(1'b0);

      // idle time catches any extra pixel
      repeat (20) @(posedge clk);
      assert (expColorQ.size() == 0 && tileCnt == 0)
      else
      begin
         errCount++;
         $display("%0d expected pixels never came out", expColorQ.size());
      end
      errCount += starLayerMixer_i.starLayerMixer_assert_i.failCount;
      $display("checks: %0d  errors: %0d", checkCount, errCount);
      if (errCount == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

// File: sources.f
+incdir+logic
logic/starMixPkg.sv
logic/tileLoader.sv
logic/planeLane.sv
logic/priorityMixer.sv
logic/starLayerMixer.sv
tb/starLayerMixer_assert.sv
tb/starLayerMixer_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

obj_dir/VstarLayerMixer_tb: sources.f $(wildcard logic/*.sv logic/*.svh tb/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f sources.f --top-module starLayerMixer_tb \
		-Mdir obj_dir -o VstarLayerMixer_tb

test: obj_dir/VstarLayerMixer_tb
	./obj_dir/VstarLayerMixer_tb | tee sim.log
	@if grep -q "ALL CHECKS PASSED" sim.log; then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
